/* hw/pitchPkg.sv */
package pitchPkg;

	// Screen geometry
	localparam int SCREEN_WIDTH = 320;
	localparam int SCREEN_HEIGHT = 240;

	typedef logic [$clog2(SCREEN_WIDTH)-1:0] xCoordT;	// Screen column
	typedef logic [$clog2(SCREEN_HEIGHT)-1:0] yCoordT;	// Screen row
	typedef logic [11:0] colourT;	// 4 bits per channel, R G B
	typedef logic [3:0] stepT;	// Pixels per move
	typedef logic [3:0] boxIndexT;	// Offset inside the ball box

	// Ball box and flight bounds
	localparam int BOX_SIZE = 10;
	localparam xCoordT START_X = 9'd310;
	localparam yCoordT START_Y = 8'd100;
	localparam yCoordT BOTTOM_Y = 8'd218;	// Lowest origin, box still on screen
	localparam yCoordT TOP_Y = 8'd0;

	localparam colourT BALL_COLOUR = 12'hF80;	// Orange
	localparam colourT BACKGROUND_COLOUR = 12'h0A0;	// Green

	// Scaled down from the real frame and rest lengths
	localparam int FRAME_CYCLES = 256;
	localparam int REST_CYCLES = 1024;
	localparam int FRAME_COUNT_BITS = $clog2(FRAME_CYCLES);
	localparam int REST_COUNT_BITS = $clog2(REST_CYCLES);

	typedef enum logic [2:0] {
		Idle,
		Launch,
		Draw,
		WaitFrame,
		Erase,
		Move,
		Rest
	} flightStateT;

endpackage

/* hw/flightControl.sv */
`timescale 1ns/100ps

module flightControl import pitchPkg::*; (
	input logic clock,
	input logic resetn,
	input logic start,
	input logic rasterDone,
	input logic frameTick,
	input logic restDone,
	input logic atLeftEdge,
	output logic loadStart,
	output logic moveBall,
	output logic drawStart,
	output logic eraseStart,
	output logic resting,
	output logic busy
);

	flightStateT state;
	flightStateT nextState;

	always_ff @(posedge clock) begin
		if (!resetn)
			state <= Idle;
		else
			state <= nextState;
	end

	// Next state
	always_comb begin
		nextState = state;
		case (state)
			Idle: begin
				if (start)
					nextState = Launch;
			end
			Launch:
				nextState = Draw;	// Ball already at start position
			Draw: begin
				if (rasterDone)
					nextState = WaitFrame;
			end
			WaitFrame: begin
				if (frameTick)
					nextState = Erase;
			end
			Erase: begin
				// Last erase at the left edge closes the flight
				if (rasterDone) begin
					if (atLeftEdge)
						nextState = Rest;
					else
						nextState = Move;
				end
			end
			Move:
				nextState = Draw;
			Rest: begin
				if (restDone)
					nextState = Idle;
			end
			default:
				nextState = Idle;
		endcase
	end

	// Steps are taken in the same cycle the start is accepted
	assign loadStart = (state == Idle) && start;

	// One move per Move visit, new coordinates ready as the draw begins
	assign moveBall = (state == Move);

	// Raster strobes fire only on the transition into Draw or Erase
	assign drawStart = (state != Draw) && (nextState == Draw);
	assign eraseStart = (state != Erase) && (nextState == Erase);

	assign resting = (state == Rest);
	assign busy = (state != Idle);

endmodule

/* hw/frameTimer.sv */
`timescale 1ns/100ps

module frameTimer import pitchPkg::*; (
	input logic clock,
	input logic resetn,
	input logic resting,
	output logic frameTick,
	output logic restDone
);

	logic [FRAME_COUNT_BITS-1:0] frameCount;
	logic [REST_COUNT_BITS-1:0] restCount;

	// Free running, independent of the flight
	always_ff @(posedge clock) begin
		if (!resetn)
			frameCount <= '0;
		else if (frameTick)
			frameCount <= '0;
		else
			frameCount <= frameCount + 1'b1;
	end

	assign frameTick = (frameCount == FRAME_COUNT_BITS'(FRAME_CYCLES - 1));

	// Rest counter only runs while the controller sits in Rest
	always_ff @(posedge clock) begin
		if (!resetn)
			restCount <= '0;
		else if (!resting || restDone)
			restCount <= '0;
		else
			restCount <= restCount + 1'b1;
	end

	// Count starts at zero in the first resting cycle
	assign restDone = resting && (restCount == REST_COUNT_BITS'(REST_CYCLES - 1));

endmodule

/* hw/ballPosition.sv */
`timescale 1ns/100ps

module ballPosition import pitchPkg::*; (
	input logic clock,
	input logic resetn,
	input logic loadStart,
	input logic moveBall,
	input stepT stepX,
	input stepT stepY,
	output xCoordT ballX,
	output yCoordT ballY,
	output logic atLeftEdge
);

	stepT stepXReg;
	stepT stepYReg;
	logic goingUp;
	yCoordT downY;	// Candidate row when moving down
	logic hitBottom;
	logic hitTop;
	logic hitLeft;

	// Steps held for the whole flight
	always_ff @(posedge clock) begin
		if (loadStart) begin
			stepXReg <= stepX;
			stepYReg <= stepY;
		end
	end

	assign downY = ballY + yCoordT'(stepYReg);
	assign hitBottom = (downY >= BOTTOM_Y);
	assign hitTop = (ballY <= TOP_Y + yCoordT'(stepYReg));
	assign hitLeft = (ballX <= xCoordT'(stepXReg));

	always_ff @(posedge clock) begin
		if (!resetn) begin
			ballX <= START_X;
			ballY <= START_Y;
			goingUp <= 1'b0;
			atLeftEdge <= 1'b0;
		end else if (loadStart) begin
			ballX <= START_X;
			ballY <= START_Y;
			goingUp <= 1'b0;	// Every flight starts downward
			atLeftEdge <= 1'b0;
		end else if (moveBall) begin
			if (hitLeft) begin
				ballX <= '0;	// Clamp at the edge
				atLeftEdge <= 1'b1;
			end else begin
				ballX <= ballX - xCoordT'(stepXReg);
			end

			// Vertical bounce between TOP_Y and BOTTOM_Y
			if (!goingUp) begin
				if (hitBottom) begin
					ballY <= BOTTOM_Y;
					goingUp <= 1'b1;
				end else begin
					ballY <= downY;
				end
			end else begin
				if (hitTop) begin
					ballY <= TOP_Y;
					goingUp <= 1'b0;
				end else begin
					ballY <= ballY - yCoordT'(stepYReg);
				end
			end
		end
	end

endmodule

/* hw/boxRaster.sv */
`timescale 1ns/100ps

module boxRaster import pitchPkg::*; (
	input logic clock,
	input logic resetn,
	input logic drawStart,
	input logic eraseStart,
	input xCoordT ballX,
	input yCoordT ballY,
	output logic pixelWrite,
	output xCoordT pixelX,
	output yCoordT pixelY,
	output colourT pixelColour,
	output logic rasterDone
);

	logic active;
	boxIndexT colIdx;
	boxIndexT rowIdx;
	colourT burstColour;
	logic lastCol;
	logic lastPixel;

	assign lastCol = (colIdx == boxIndexT'(BOX_SIZE - 1));
	assign lastPixel = lastCol && (rowIdx == boxIndexT'(BOX_SIZE - 1));

	// Burst control, one pixel per cycle
	always_ff @(posedge clock) begin
		if (!resetn) begin
			active <= 1'b0;
			colIdx <= '0;
			rowIdx <= '0;
		end else if (drawStart || eraseStart) begin
			active <= 1'b1;
			colIdx <= '0;
			rowIdx <= '0;
		end else if (active) begin
			if (lastPixel) begin
				active <= 1'b0;
				colIdx <= '0;
				rowIdx <= '0;
			end else if (lastCol) begin
				colIdx <= '0;	// Next row
				rowIdx <= rowIdx + 1'b1;
			end else begin
				colIdx <= colIdx + 1'b1;
			end
		end
	end

	// Colour chosen once per burst
	always_ff @(posedge clock) begin
		if (drawStart)
			burstColour <= BALL_COLOUR;
		else if (eraseStart)
			burstColour <= BACKGROUND_COLOUR;
	end

	// Origin is stable for the whole burst
	assign pixelX = ballX + xCoordT'(colIdx);
	assign pixelY = ballY + yCoordT'(rowIdx);
	assign pixelColour = burstColour;
	assign pixelWrite = active;
	assign rasterDone = active && lastPixel;	// Same cycle as the last write

endmodule

/* hw/pitchTop.sv */
`timescale 1ns/100ps

module pitchTop import pitchPkg::*; (
	input logic clock,
	input logic resetn,
	input logic start,
	input stepT stepX,
	input stepT stepY,
	output logic pixelWrite,
	output xCoordT pixelX,
	output yCoordT pixelY,
	output colourT pixelColour,
	output logic busy
);

	logic loadStart;
	logic moveBall;
	logic drawStart;
	logic eraseStart;
	logic resting;
	logic rasterDone;
	logic frameTick;
	logic restDone;
	logic atLeftEdge;
	xCoordT ballX;
	yCoordT ballY;

	flightControl control (
		.clock(clock),
		.resetn(resetn),
		.start(start),
		.rasterDone(rasterDone),
		.frameTick(frameTick),
		.restDone(restDone),
		.atLeftEdge(atLeftEdge),
		.loadStart(loadStart),
		.moveBall(moveBall),
		.drawStart(drawStart),
		.eraseStart(eraseStart),
		.resting(resting),
		.busy(busy)
	);

	frameTimer timer (
		.clock(clock),
		.resetn(resetn),
		.resting(resting),
		.frameTick(frameTick),
		.restDone(restDone)
	);

	ballPosition ball (
		.clock(clock),
		.resetn(resetn),
		.loadStart(loadStart),
		.moveBall(moveBall),
		.stepX(stepX),
		.stepY(stepY),
		.ballX(ballX),
		.ballY(ballY),
		.atLeftEdge(atLeftEdge)
	);

	// Single raster serves both draw and erase
	boxRaster raster (
		.clock(clock),
		.resetn(resetn),
		.drawStart(drawStart),
		.eraseStart(eraseStart),
		.ballX(ballX),
		.ballY(ballY),
		.pixelWrite(pixelWrite),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelColour(pixelColour),
		.rasterDone(rasterDone)
	);

endmodule

/* bench/pitchTopTb.sv */
`timescale 1ns/100ps

module pitchTopTb import pitchPkg::*; ();

	localparam int CLOCK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2;
	localparam int RESET_CYCLES = 8;
	localparam int RUNS = 6;
	localparam logic [7:0] LFSR_SEED = 8'd66;
	localparam int BURST_LENGTH = BOX_SIZE * BOX_SIZE;
	// Up to 40 draw loops per flight of one frame and two bursts each
	localparam longint WATCHDOG_CYCLES =
		RUNS * (40 * (FRAME_CYCLES + 2 * BURST_LENGTH + 8) + REST_CYCLES);

	logic clock;
	logic resetn;
	logic start;
	stepT stepX;
	stepT stepY;
	logic pixelWrite;
	xCoordT pixelX;
	yCoordT pixelY;
	colourT pixelColour;
	logic busy;

	logic [7:0] lfsr;

	// Reference model of the flight
	logic armed = 1'b0;	// Outputs defined from the first reset edge on
	logic startSeen;
	logic flightActive;
	logic flightOver;	// Last erase done and rest running
	logic eraseNext;
	logic inBurst;
	logic goingUp;
	int orgX;
	int orgY;
	int stepXLatch;
	int stepYLatch;
	int pixIdx;
	int restWait;
	int flightsDone;
	int curIdx;
	int expX;
	int expY;
	colourT expColour;

	pitchTop uut (
		.clock(clock),
		.resetn(resetn),
		.start(start),
		.stepX(stepX),
		.stepY(stepY),
		.pixelWrite(pixelWrite),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelColour(pixelColour),
		.busy(busy)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	task automatic reportMismatch(input string testName, input int expected, input int actual);
		$display("[ERROR] %s: expected %0d, actual %0d", testName, expected, actual);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic reportFailure(input string what);
		$display("Failure: %s", what);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	// Fibonacci LFSR with taps 8 6 5 4
	function automatic logic [7:0] lfsrStep(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic randomBits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			value = (value << 1) | int'(lfsr[7]);
			lfsr = lfsrStep(lfsr);
		end
	endtask

	always_comb begin
		curIdx = inBurst ? pixIdx : 0;
		expX = orgX + curIdx % BOX_SIZE;	// Row-major walk
		expY = orgY + curIdx / BOX_SIZE;
		expColour = eraseNext ? BACKGROUND_COLOUR : BALL_COLOUR;
	end

	always @(posedge clock) begin
		if (!resetn) begin
			armed <= 1'b1;
			startSeen <= 1'b0;
			flightActive <= 1'b0;
			flightOver <= 1'b0;
			inBurst <= 1'b0;
			pixIdx <= 0;
			flightsDone <= 0;
		end else begin
			if (start)
				startSeen <= 1'b1;
			if (flightOver) begin
				restWait <= restWait + 1;
				if (!busy) begin
					flightOver <= 1'b0;
					flightActive <= 1'b0;
					flightsDone <= flightsDone + 1;
				end
			end
			if (pixelWrite) begin
				if (curIdx == BURST_LENGTH - 1) begin
					inBurst <= 1'b0;
					pixIdx <= 0;
					if (!eraseNext) begin
						eraseNext <= 1'b1;	// Erase at the same origin
					end else if (orgX == 0) begin
						flightOver <= 1'b1;
						restWait <= 1;
					end else begin
						eraseNext <= 1'b0;
						orgX <= (orgX > stepXLatch) ? orgX - stepXLatch : 0;
						// Bounce between the top and bottom bounds
						if (!goingUp) begin
							if (orgY + stepYLatch >= int'(BOTTOM_Y)) begin
								orgY <= int'(BOTTOM_Y);
								goingUp <= 1'b1;
							end else begin
								orgY <= orgY + stepYLatch;
							end
						end else begin
							if (orgY - stepYLatch <= int'(TOP_Y)) begin
								orgY <= int'(TOP_Y);
								goingUp <= 1'b0;
							end else begin
								orgY <= orgY - stepYLatch;
							end
						end
					end
				end else begin
					inBurst <= 1'b1;
					pixIdx <= curIdx + 1;
				end
			end
			if (start && !busy) begin	// Accepted start
				flightActive <= 1'b1;
				flightOver <= 1'b0;
				eraseNext <= 1'b0;
				goingUp <= 1'b0;
				orgX <= int'(START_X);
				orgY <= int'(START_Y);
				stepXLatch <= int'(stepX);
				stepYLatch <= int'(stepY);
			end
		end
	end

	resetQuiet: assert property (@(posedge clock) disable iff (!armed)
		startSeen || (!pixelWrite && !busy))
		else reportFailure("resetQuiet: pixelWrite or busy went high before the first start");

	burstGap: assert property (@(posedge clock) disable iff (!armed) !inBurst || pixelWrite)
		else reportFailure("burstShape: a burst stopped before all pixels of the box");

	strayWrite: assert property (@(posedge clock) disable iff (!armed)
		!pixelWrite || (flightActive && !flightOver))
		else reportFailure("burstShape: pixel write outside the draw and erase sequence");

	pixelXCheck: assert property (@(posedge clock) disable iff (!armed)
		!pixelWrite || int'(pixelX) == expX)
		else reportMismatch("flightPath pixelX", expX, int'(pixelX));

	pixelYCheck: assert property (@(posedge clock) disable iff (!armed)
		!pixelWrite || int'(pixelY) == expY)
		else reportMismatch("flightPath pixelY", expY, int'(pixelY));

	colourCheck: assert property (@(posedge clock) disable iff (!armed)
		!pixelWrite || pixelColour == expColour)
		else reportMismatch("burstShape colour", int'(expColour), int'(pixelColour));

	busyInFlight: assert property (@(posedge clock) disable iff (!armed)
		!(flightActive && !flightOver) || busy)
		else reportMismatch("flightEnd busy", 1, int'(busy));

	// busy holds through the rest and drops right after it
	busyInRest: assert property (@(posedge clock) disable iff (!armed)
		!flightOver || busy == (restWait <= REST_CYCLES))
		else reportMismatch("flightEnd busy", int'(restWait <= REST_CYCLES), int'(busy));

	task automatic waitCycles(input int count);
		repeat (count) @(posedge clock);
		#DRIVE_DELAY;
	endtask

	// One-cycle start strobe with fresh steps
	task automatic pulseStart();
		int bits;
		randomBits(3, bits);
		stepX = stepT'(8 + bits);
		randomBits(4, bits);
		stepY = stepT'(1 + bits % 15);
		start = 1'b1;
		waitCycles(1);
		start = 1'b0;
	endtask

	initial begin
		int gap;
		resetn = 1'b0;
		start = 1'b0;
		stepX = '0;
		stepY = '0;
		lfsr = LFSR_SEED;
		waitCycles(RESET_CYCLES);
		resetn = 1'b1;
		waitCycles(20);	// Idle stretch before the first start
		for (int run = 0; run < RUNS; run++) begin
			pulseStart();
			// Starts with other steps while busy must be ignored
			for (int k = 0; k < 3; k++) begin
				randomBits(7, gap);
				waitCycles(40 + gap);
				if (busy)
					pulseStart();
			end
			while (busy)
				waitCycles(1);
			waitCycles(5);
		end
		if (flightsDone != RUNS)
			reportFailure("not every flight was completed");
		else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		reportFailure("simulation hung, the watchdog time ran out");
	end

endmodule

/* pitchTop.f */
hw/pitchPkg.sv
hw/flightControl.sv
hw/frameTimer.sv
hw/ballPosition.sv
hw/boxRaster.sv
hw/pitchTop.sv
bench/pitchTopTb.sv

/* run.sh */
#!/bin/sh
# Build and run the pitchTop testbench with Verilator.
# Exit status is nonzero when the testbench stops with $fatal.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module pitchTopTb \
	-f pitchTop.f \
	-o pitchTopSim

./obj_dir/pitchTopSim
